// ==== cache_macros.svh ====
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// pipeline address width
`define CACHE_ADDR_W 32
// one bus beat, one returned word
`define CACHE_DATA_W 64

// address split: tag | index | offset
`define CACHE_OFFSET_W 5
`define CACHE_INDEX_W 6
`define CACHE_TAG_W 21

// four 64-bit words per 32-byte line
`define CACHE_BEAT_W 2

`endif

// ==== cache_pkg.sv ====
`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

  // one pipeline address split into its cache fields
  typedef struct packed {
    logic [`CACHE_TAG_W-1:0]    tag;
    logic [`CACHE_INDEX_W-1:0]  index;
    logic [`CACHE_OFFSET_W-1:0] offset;
  } addrFieldsT;

  // payload of one tag RAM word
  typedef struct packed {
    logic [`CACHE_TAG_W-1:0] tag;
  } tagEntryT;

  // lookup result, valid in COMPARE
  typedef struct packed {
    logic [1:0] wayHit;
    logic       hitWay;
    logic       anyHit;
  } hitInfoT;

  // line install at the end of a refill
  typedef struct packed {
    logic                      write;
    logic                      way;
    logic [`CACHE_INDEX_W-1:0] index;
    logic [`CACHE_TAG_W-1:0]   tag;
  } refillCmdT;

  typedef struct packed {
    logic                     valid;
    logic                     last;
    logic [`CACHE_DATA_W-1:0] data;
  } busBeatT;

endpackage

`default_nettype wire

// ==== cacheSram.sv ====
`timescale 1ns/1ps
`default_nettype none

// generic single-port RAM, one cycle read latency
module cacheSram #(
  parameter type entryT = logic [63:0],
  parameter int  DEPTH  = 64
) (
  input  wire logic                     clk,
  input  wire logic                     en_i,
  input  wire logic                     we_i,
  input  wire logic [$clog2(DEPTH)-1:0] addr_i,
  input  wire entryT                    wdata_i,
  output entryT                         rdata_o
);

  entryT mem [DEPTH];

  // read returns the old word when written in the same cycle
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end
      rdata_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

// ==== cacheMeta.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cacheMeta (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      lookupEn_i,
  input  wire logic [`CACHE_INDEX_W-1:0] lookupIndex_i,
  input  wire logic [`CACHE_TAG_W-1:0]   reqTag_i,
  input  wire cache_pkg::refillCmdT      refill_i,
  input  wire logic                      flushEn_i,
  output cache_pkg::hitInfoT             hitInfo_o,
  output logic                           victimWay_o
);

  localparam int Sets = 1 << `CACHE_INDEX_W;

  logic [1:0][Sets-1:0]       validArr;
  logic [Sets-1:0]            lruArr;
  logic [1:0]                 validQ;
  logic [1:0]                 wayHit;
  logic [`CACHE_INDEX_W-1:0]  latchIdx;
  logic [`CACHE_INDEX_W-1:0]  ramAddr;
  logic                       lookupQ;
  cache_pkg::tagEntryT        wrEntry;
  cache_pkg::tagEntryT        tagQ [2];

  // refill write and lookup never share a cycle
  assign ramAddr = refill_i.write ? refill_i.index : lookupIndex_i;
  assign wrEntry.tag = refill_i.tag;

  for (genvar w = 0; w < 2; w++) begin : gTagWay
    cacheSram #(
      .entryT(cache_pkg::tagEntryT),
      .DEPTH (Sets)
    ) i_tagRam (
      .clk    (clk),
      .en_i   (lookupEn_i | refill_i.write),
      .we_i   (refill_i.write & (refill_i.way == 1'(w))),
      .addr_i (ramAddr),
      .wdata_i(wrEntry),
      .rdata_o(tagQ[w])
    );
  end

  // index of the set under lookup, aligned with the tag RAM output
  always_ff @(posedge clk) begin
    if (lookupEn_i) begin
      latchIdx <= lookupIndex_i;
    end
  end

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayHit[w] = validQ[w] & (tagQ[w].tag == reqTag_i);
    end
  end

  assign hitInfo_o = '{wayHit: wayHit, hitWay: wayHit[1], anyHit: |wayHit};

  // invalid way first, then the least recently used one
  assign victimWay_o = !validQ[0] ? 1'b0 : (!validQ[1] ? 1'b1 : lruArr[latchIdx]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr <= '0;
      lruArr   <= '0;
      validQ   <= '0;
      lookupQ  <= 1'b0;
    end else begin
      lookupQ <= lookupEn_i;
      if (lookupEn_i) begin
        validQ <= {validArr[1][lookupIndex_i], validArr[0][lookupIndex_i]};
      end
      if (flushEn_i) begin
        validArr <= '0;
        lruArr   <= '0;
      end else if (refill_i.write) begin
        validArr[refill_i.way][refill_i.index] <= 1'b1;
        lruArr[refill_i.index] <= ~refill_i.way;
      end else if (lookupQ && hitInfo_o.anyHit) begin
        // COMPARE cycle hit, the other way becomes LRU
        lruArr[latchIdx] <= ~hitInfo_o.hitWay;
      end
    end
  end

endmodule

`default_nettype wire

// ==== cacheCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cacheCtrl (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  // pipeline side
  input  wire logic                      valid_i,
  input  wire logic [`CACHE_ADDR_W-1:0]  addr_i,
  input  wire logic                      flush_i,
  output logic                           addr_ok_o,
  output logic                           data_ok_o,
  output logic [`CACHE_DATA_W-1:0]       rd_data_o,
  // bus side
  output logic                           cacheRdValid_o,
  output logic [`CACHE_ADDR_W-1:0]       cacheAddr_o,
  input  wire logic                      rdDataValid_i,
  input  wire logic                      rdLast_i,
  input  wire logic [`CACHE_DATA_W-1:0]  rdData_i,
  // metadata block
  output logic                           lookupEn_o,
  output logic [`CACHE_INDEX_W-1:0]      lookupIndex_o,
  output logic [`CACHE_TAG_W-1:0]        reqTag_o,
  input  wire cache_pkg::hitInfoT        hitInfo_i,
  input  wire logic                      victimWay_i,
  output cache_pkg::refillCmdT           refill_o,
  output logic                           flushEn_o
);

  localparam int WordAddrW = `CACHE_INDEX_W + `CACHE_BEAT_W;

  typedef enum logic [1:0] {stIdle, stCompare, stRefill, stReplay} stateT;

  stateT                       state, stateNext;
  cache_pkg::addrFieldsT       inAddr;
  cache_pkg::addrFieldsT       reqAddr;
  cache_pkg::busBeatT          beat;
  logic                        accept;
  logic                        beatWr;
  logic                        victimQ;
  logic [`CACHE_BEAT_W-1:0]    beatCnt;
  logic [WordAddrW-1:0]        dataAddr;
  logic [`CACHE_DATA_W-1:0]    wayData [2];

  assign inAddr = cache_pkg::addrFieldsT'(addr_i);
  assign beat = '{valid: rdDataValid_i, last: rdLast_i, data: rdData_i};

  // a flush strobe holds off new requests
  assign addr_ok_o = !flush_i &&
                     (state == stIdle || (state == stCompare && hitInfo_i.anyHit));
  assign accept    = valid_i && addr_ok_o;
  assign flushEn_o = (state == stIdle) && flush_i;
  assign beatWr    = (state == stRefill) && beat.valid;

  always_comb begin
    stateNext = state;
    case (state)
      stIdle: begin
        if (accept) begin
          stateNext = stCompare;
        end
      end
      stCompare: begin
        if (!hitInfo_i.anyHit) begin
          stateNext = stRefill;
        end else if (!accept) begin
          stateNext = stIdle;
        end
      end
      stRefill: begin
        if (beat.valid && beat.last) begin
          stateNext = stReplay;
        end
      end
      default: begin
        stateNext = stCompare;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= stIdle;
      beatCnt <= '0;
      victimQ <= 1'b0;
    end else begin
      state <= stateNext;
      if (state == stCompare && !hitInfo_i.anyHit) begin
        victimQ <= victimWay_i;
      end
      // four beats wrap the counter back to zero
      if (beatWr) begin
        beatCnt <= beatCnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr <= inAddr;
    end
  end

  // replay repeats the lookup of the stalled request
  assign lookupEn_o    = accept || (state == stReplay);
  assign lookupIndex_o = accept ? inAddr.index : reqAddr.index;
  assign reqTag_o      = reqAddr.tag;

  assign cacheRdValid_o = (state == stRefill);
  assign cacheAddr_o    = {reqAddr.tag, reqAddr.index, {`CACHE_OFFSET_W{1'b0}}};

  assign refill_o = '{write: beatWr && beat.last, way: victimQ,
                      index: reqAddr.index, tag: reqAddr.tag};

  // word address is index plus word within the line
  always_comb begin
    if (state == stRefill) begin
      dataAddr = {reqAddr.index, beatCnt};
    end else if (accept) begin
      dataAddr = {inAddr.index, inAddr.offset[`CACHE_OFFSET_W-1 -: `CACHE_BEAT_W]};
    end else begin
      dataAddr = {reqAddr.index, reqAddr.offset[`CACHE_OFFSET_W-1 -: `CACHE_BEAT_W]};
    end
  end

  for (genvar w = 0; w < 2; w++) begin : gDataWay
    cacheSram #(
      .entryT(logic [`CACHE_DATA_W-1:0]),
      .DEPTH (1 << WordAddrW)
    ) i_dataRam (
      .clk    (clk),
      .en_i   (lookupEn_o | beatWr),
      .we_i   (beatWr & (victimQ == 1'(w))),
      .addr_i (dataAddr),
      .wdata_i(beat.data),
      .rdata_o(wayData[w])
    );
  end

  assign data_ok_o = (state == stCompare) && hitInfo_i.anyHit;
  assign rd_data_o = hitInfo_i.hitWay ? wayData[1] : wayData[0];

endmodule

`default_nettype wire

// ==== cacheTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cacheTop (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic                     valid_i,
  input  wire logic [`CACHE_ADDR_W-1:0] addr_i,
  input  wire logic                     flush_i,
  output logic                          addr_ok_o,
  output logic                          data_ok_o,
  output logic [`CACHE_DATA_W-1:0]      rd_data_o,
  output logic                          cacheRdValid_o,
  output logic [`CACHE_ADDR_W-1:0]      cacheAddr_o,
  input  wire logic                     rdDataValid_i,
  input  wire logic                     rdLast_i,
  input  wire logic [`CACHE_DATA_W-1:0] rdData_i
);

  logic                      lookupEn;
  logic [`CACHE_INDEX_W-1:0] lookupIndex;
  logic [`CACHE_TAG_W-1:0]   reqTag;
  cache_pkg::hitInfoT        hitInfo;
  logic                      victimWay;
  cache_pkg::refillCmdT      refillCmd;
  logic                      flushEn;

  cacheCtrl i_ctrl (
    .clk, .rst_n, .valid_i, .addr_i, .flush_i,
    .addr_ok_o, .data_ok_o, .rd_data_o,
    .cacheRdValid_o, .cacheAddr_o, .rdDataValid_i, .rdLast_i, .rdData_i,
    .lookupEn_o   (lookupEn),
    .lookupIndex_o(lookupIndex),
    .reqTag_o     (reqTag),
    .hitInfo_i    (hitInfo),
    .victimWay_i  (victimWay),
    .refill_o     (refillCmd),
    .flushEn_o    (flushEn)
  );

  cacheMeta i_meta (
    .clk, .rst_n,
    .lookupEn_i   (lookupEn),
    .lookupIndex_i(lookupIndex),
    .reqTag_i     (reqTag),
    .refill_i     (refillCmd),
    .flushEn_i    (flushEn),
    .hitInfo_o    (hitInfo),
    .victimWay_o  (victimWay)
  );

endmodule

`default_nettype wire

// ==== tb_clkGen.sv ====
`timescale 1ns/1ps
`default_nettype none

// free-running clock and a reset released on a falling edge
module tb_clkGen #(
  parameter int PeriodNs    = 100,
  parameter int ResetCycles = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb_memModel.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

// bus responder, the word at address a reads as {a, ~a}
module tb_memModel #(
  parameter int unsigned Seed = 32'h8dd7
) (
  input  wire logic                     clk,
  input  wire logic                     cacheRdValid_i,
  input  wire logic [`CACHE_ADDR_W-1:0] cacheAddr_i,
  output logic                          rdDataValid_o,
  output logic                          rdLast_o,
  output logic [`CACHE_DATA_W-1:0]      rdData_o
);

  logic [`CACHE_ADDR_W-1:0] wordAddr;
  int unsigned              gap;

  initial begin
    void'($urandom(Seed));
    rdDataValid_o = 1'b0;
    rdLast_o      = 1'b0;
    rdData_o      = '0;
    forever begin
      @(negedge clk);
      if (cacheRdValid_i) begin
        for (int b = 0; b < 4; b++) begin
          // up to three idle cycles before each beat
          gap = $urandom % 4;
          repeat (gap) @(negedge clk);
          wordAddr      = cacheAddr_i + 32'(b * 8);
          rdData_o      = {wordAddr, ~wordAddr};
          rdDataValid_o = 1'b1;
          rdLast_o      = (b == 3);
          @(negedge clk);
          rdDataValid_o = 1'b0;
          rdLast_o      = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== cache_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cacheAsserts (
  input wire logic                     clk,
  input wire logic                     rst_n,
  input wire logic                     addrOk_i,
  input wire logic                     dataOk_i,
  input wire logic                     cacheRdValid_i,
  input wire logic [`CACHE_ADDR_W-1:0] cacheAddr_i,
  input wire logic                     rdDataValid_i,
  input wire logic                     rdLast_i,
  input wire logic [`CACHE_DATA_W-1:0] rdData_i
);

  cache_pkg::busBeatT beat;

  assign beat = '{valid: rdDataValid_i, last: rdLast_i, data: rdData_i};

  // line address held for the whole refill
  refillAddrStable: assert property (@(posedge clk) disable iff (!rst_n)
    cacheRdValid_i |=> !cacheRdValid_i || $stable(cacheAddr_i))
    else $error("cacheAddr_o changed while cacheRdValid_o was high");

  noDataDuringRefill: assert property (@(posedge clk) disable iff (!rst_n)
    !(dataOk_i && cacheRdValid_i))
    else $error("data_ok_o high together with cacheRdValid_o");

  noAcceptDuringRefill: assert property (@(posedge clk) disable iff (!rst_n)
    cacheRdValid_i |-> !addrOk_i)
    else $error("addr_ok_o high during a refill");

  // beats only answer an open line request
  beatInsideRefill: assert property (@(posedge clk) disable iff (!rst_n)
    beat.valid |-> cacheRdValid_i && !$isunknown(beat.data))
    else $error("bus beat outside a refill");

endmodule

`default_nettype wire

// ==== cacheTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cacheTb;

  localparam int ResetCycles    = 16;
  localparam int CyclesPerEntry = 40;
  localparam int NumEntries     = 18;

  typedef struct packed {
    logic [`CACHE_ADDR_W-1:0] addr;
    logic                     flush;
    logic                     refill;
    logic                     chain;
  } stimT;

  // chain issues the request while the one before is still in flight
  stimT stimTable [NumEntries] = '{
    '{32'h0000_0060, 1'b0, 1'b1, 1'b0},
    '{32'h0000_0068, 1'b0, 1'b0, 1'b0},
    '{32'h0000_0070, 1'b0, 1'b0, 1'b1},
    '{32'h0000_0078, 1'b0, 1'b0, 1'b1},
    '{32'h0000_0060, 1'b0, 1'b0, 1'b1},
    '{32'h0000_0868, 1'b0, 1'b1, 1'b0},
    '{32'h0000_0070, 1'b0, 1'b0, 1'b0},
    '{32'h0000_1078, 1'b0, 1'b1, 1'b0},
    '{32'h0000_0060, 1'b0, 1'b0, 1'b0},
    '{32'h0000_0860, 1'b0, 1'b1, 1'b0},
    '{32'h1234_5680, 1'b0, 1'b1, 1'b0},
    '{32'h1234_5698, 1'b0, 1'b0, 1'b1},
    '{32'h0000_0060, 1'b1, 1'b1, 1'b0},
    '{32'h1234_5688, 1'b0, 1'b1, 1'b0},
    '{32'h0000_0868, 1'b0, 1'b1, 1'b0},
    '{32'h0000_0878, 1'b0, 1'b0, 1'b1},
    '{32'habcd_e000, 1'b0, 1'b1, 1'b1},
    '{32'habcd_e018, 1'b0, 1'b0, 1'b1}
  };

  logic                     clk;
  logic                     rst_n;
  logic                     valid;
  logic [`CACHE_ADDR_W-1:0] addr;
  logic                     flush;
  logic                     addrOk;
  logic                     dataOk;
  logic [`CACHE_DATA_W-1:0] rdData;
  logic                     cacheRdValid;
  logic [`CACHE_ADDR_W-1:0] cacheAddr;
  logic                     rdDataValid;
  logic                     rdLast;
  logic [`CACHE_DATA_W-1:0] rdDataBus;

  int                       pending [$];
  int                       nextIdx;
  int                       doneCnt;
  int                       quiet;
  logic                     refillSeen;
  logic                     flushDone;
  logic                     okNow;
  logic [`CACHE_ADDR_W-1:0] wordAddr;
  stimT                     cur;

  tb_clkGen #(.PeriodNs(100), .ResetCycles(ResetCycles)) i_clkGen (
    .clk_o  (clk),
    .rst_n_o(rst_n)
  );

  tb_memModel #(.Seed(32'h8dd7)) i_mem (
    .clk           (clk),
    .cacheRdValid_i(cacheRdValid),
    .cacheAddr_i   (cacheAddr),
    .rdDataValid_o (rdDataValid),
    .rdLast_o      (rdLast),
    .rdData_o      (rdDataBus)
  );

  cacheTop i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_i       (valid),
    .addr_i        (addr),
    .flush_i       (flush),
    .addr_ok_o     (addrOk),
    .data_ok_o     (dataOk),
    .rd_data_o     (rdData),
    .cacheRdValid_o(cacheRdValid),
    .cacheAddr_o   (cacheAddr),
    .rdDataValid_i (rdDataValid),
    .rdLast_i      (rdLast),
    .rdData_i      (rdDataBus)
  );

  bind cacheTop cacheAsserts i_asserts (
    .clk           (clk),
    .rst_n         (rst_n),
    .addrOk_i      (addr_ok_o),
    .dataOk_i      (data_ok_o),
    .cacheRdValid_i(cacheRdValid_o),
    .cacheAddr_i   (cacheAddr_o),
    .rdDataValid_i (rdDataValid_i),
    .rdLast_i      (rdLast_i),
    .rdData_i      (rdData_i)
  );

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic compareValue(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    if (got !== exp) begin
      abortRun($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  initial begin
    repeat (ResetCycles + NumEntries * CyclesPerEntry) @(posedge clk);
    abortRun("run timed out before every request returned its data");
  end

  initial begin
    valid      = 1'b0;
    addr       = '0;
    flush      = 1'b0;
    nextIdx    = 0;
    doneCnt    = 0;
    quiet      = 0;
    refillSeen = 1'b0;
    flushDone  = 1'b0;
    repeat (ResetCycles) begin
      @(negedge clk);
      compareValue("data_ok_o", 64'(dataOk), 64'd0);
      compareValue("cacheRdValid_o", 64'(cacheRdValid), 64'd0);
    end
    @(negedge clk);
    compareValue("addr_ok_o", 64'(addrOk), 64'd1);
    while (doneCnt < NumEntries) begin
      @(negedge clk);
      quiet = (pending.size() == 0) ? quiet + 1 : 0;
      // refills and data always belong to the oldest request in flight
      if (cacheRdValid) begin
        if (pending.size() == 0) begin
          abortRun("cache requested a line with no request pending");
        end
        compareValue("cacheAddr_o", 64'(cacheAddr),
                     64'({stimTable[pending[0]].addr[31:5], 5'b0}));
        refillSeen = 1'b1;
      end
      if (dataOk) begin
        if (pending.size() == 0) begin
          abortRun("data_ok_o pulsed with no request pending");
        end
        wordAddr = {stimTable[pending[0]].addr[31:3], 3'b0};
        compareValue("rd_data_o", rdData, {wordAddr, ~wordAddr});
        compareValue("cacheRdValid_o seen", 64'(refillSeen),
                     64'(stimTable[pending[0]].refill));
        refillSeen = 1'b0;
        void'(pending.pop_front());
        doneCnt++;
      end
      okNow = addrOk;
      valid = 1'b0;
      flush = 1'b0;
      if (nextIdx < NumEntries) begin
        cur = stimTable[nextIdx];
        if (cur.flush && !flushDone) begin
          // two quiet cycles put the FSM back in IDLE
          if (quiet >= 2) begin
            flush     = 1'b1;
            flushDone = 1'b1;
            quiet     = 0;
          end
        end else if (cur.chain || quiet >= 2) begin
          valid = 1'b1;
          addr  = cur.addr;
          if (okNow) begin
            pending.push_back(nextIdx);
            nextIdx++;
            flushDone = 1'b0;
          end
        end
      end
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
cache_pkg.sv
cacheSram.sv
cacheMeta.sv
cacheCtrl.sv
cacheTop.sv
tb_clkGen.sv
tb_memModel.sv
cache_asserts.sv
cacheTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := cacheTb
FILELIST  := all.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --top-module $(TOP) -Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only --timing --assert -Wall --top-module $(TOP)

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := cache_macros.svh

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
